// File: Makefile
# Verilator build and run for uart_mem_tester

VERILATOR   ?= verilator
TOP         ?= tb_uart_mem_tester
FILELIST    ?= uart_mem_tester.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --assert -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+$(ERROR_LIMIT) 2>&1 | tee $(LOG)
	@if grep -q -x "All checks passed" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/mcb_port_if.sv
`timescale 1ns/10ps

interface mcb_port_if (
	input logic clk
);

	// command path
	logic                  cmd_en;
	mem_pkg::cmd_instr_t   cmd_instr;
	mem_pkg::byte_addr_t   cmd_byte_addr;
	logic                  cmd_full;

	// write path
	logic                  wr_en;
	mem_pkg::word_t        wr_data;
	logic                  wr_full;

	// read path
	logic                  rd_en;
	mem_pkg::word_t        rd_data;
	logic                  rd_empty;

	// user side, issues commands and moves data
	modport master (
		input  clk,
		output cmd_en, cmd_instr, cmd_byte_addr, wr_en, wr_data, rd_en,
		input  cmd_full, wr_full, rd_data, rd_empty
	);

	// controller side
	modport slave (
		input  clk,
		input  cmd_en, cmd_instr, cmd_byte_addr, wr_en, wr_data, rd_en,
		output cmd_full, wr_full, rd_data, rd_empty
	);

endinterface

// File: rtl/mcb_port_memory.sv
`timescale 1ns/10ps

module mcb_port_memory (
	input logic       clk,
	input logic       rst_n,
	mcb_port_if.slave port
);

	localparam int ptr_last = mem_pkg::fifo_depth - 1;

	mem_pkg::word_t mem [mem_pkg::mem_words];

	// command accepted last cycle, executes now
	logic                            pend;
	mem_pkg::cmd_instr_t             pend_instr;
	logic [mem_pkg::mem_addr_w-1:0]  pend_addr;
	logic                            cmd_acc;

	mem_pkg::word_t                  wf_mem [mem_pkg::fifo_depth];
	logic [mem_pkg::fifo_ptr_w-1:0]  wf_wptr;
	logic [mem_pkg::fifo_ptr_w-1:0]  wf_rptr;
	logic [mem_pkg::fifo_cnt_w-1:0]  wf_cnt;
	logic                            wf_push;
	logic                            wf_pop;

	mem_pkg::word_t                  rf_mem [mem_pkg::fifo_depth];
	logic [mem_pkg::fifo_ptr_w-1:0]  rf_wptr;
	logic [mem_pkg::fifo_ptr_w-1:0]  rf_rptr;
	logic [mem_pkg::fifo_cnt_w-1:0]  rf_cnt;
	logic                            rf_push;
	logic                            rf_pop;

	// read pipeline, one stage per latency cycle
	logic                            rd_vld  [mem_pkg::read_latency];
	logic [mem_pkg::mem_addr_w-1:0]  rd_addr [mem_pkg::read_latency];

	assign cmd_acc = port.cmd_en && !port.cmd_full;
	assign wf_push = port.wr_en && !port.wr_full;
	assign wf_pop  = pend && pend_instr == mem_pkg::cmd_write && wf_cnt != '0;
	assign rf_push = rd_vld[mem_pkg::read_latency-1]
		&& rf_cnt != mem_pkg::fifo_cnt_w'(mem_pkg::fifo_depth);
	assign rf_pop  = port.rd_en && !port.rd_empty;

	assign port.cmd_full = pend;
	assign port.wr_full  = (wf_cnt == mem_pkg::fifo_cnt_w'(mem_pkg::fifo_depth));
	assign port.rd_empty = (rf_cnt == '0);
	// head of the read fifo
	assign port.rd_data  = rf_mem[rf_rptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend    <= 1'b0;
			wf_wptr <= '0;
			wf_rptr <= '0;
			wf_cnt  <= '0;
			rf_wptr <= '0;
			rf_rptr <= '0;
			rf_cnt  <= '0;
			for (int i = 0; i < mem_pkg::read_latency; i++)
				rd_vld[i] <= 1'b0;
		end else begin
			pend <= cmd_acc;
			rd_vld[0] <= cmd_acc && port.cmd_instr == mem_pkg::cmd_read;
			for (int i = 1; i < mem_pkg::read_latency; i++)
				rd_vld[i] <= rd_vld[i-1];
			// pointers wrap at depth
			if (wf_push)
				wf_wptr <= (wf_wptr == ptr_last) ? '0 : wf_wptr + 1'b1;
			if (wf_pop)
				wf_rptr <= (wf_rptr == ptr_last) ? '0 : wf_rptr + 1'b1;
			if (wf_push && !wf_pop)
				wf_cnt <= wf_cnt + 1'b1;
			else if (wf_pop && !wf_push)
				wf_cnt <= wf_cnt - 1'b1;
			if (rf_push)
				rf_wptr <= (rf_wptr == ptr_last) ? '0 : rf_wptr + 1'b1;
			if (rf_pop)
				rf_rptr <= (rf_rptr == ptr_last) ? '0 : rf_rptr + 1'b1;
			if (rf_push && !rf_pop)
				rf_cnt <= rf_cnt + 1'b1;
			else if (rf_pop && !rf_push)
				rf_cnt <= rf_cnt - 1'b1;
		end
	end

	// storage and addresses carry no reset
	always_ff @(posedge clk) begin
		if (cmd_acc) begin
			pend_instr <= port.cmd_instr;
			pend_addr  <= port.cmd_byte_addr[mem_pkg::mem_addr_w+1:2];
		end
		rd_addr[0] <= port.cmd_byte_addr[mem_pkg::mem_addr_w+1:2];
		for (int i = 1; i < mem_pkg::read_latency; i++)
			rd_addr[i] <= rd_addr[i-1];
		if (wf_push)
			wf_mem[wf_wptr] <= port.wr_data;
		// write lands one cycle after accept
		if (wf_pop)
			mem[pend_addr] <= wf_mem[wf_rptr];
		if (rf_push)
			rf_mem[rf_wptr] <= mem[rd_addr[mem_pkg::read_latency-1]];
	end

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

	// one data word on the user port
	typedef logic [31:0] word_t;

	// word address as it arrives in a frame
	typedef logic [7:0] word_addr_t;

	// byte address on the command path, word address times four
	typedef logic [29:0] byte_addr_t;

	// controller instruction codes
	typedef enum logic [2:0] {
		cmd_write = 3'd0,
		cmd_read  = 3'd1
	} cmd_instr_t;

	localparam int mem_words    = 256;
	localparam int fifo_depth   = 4;
	localparam int read_latency = 2;

	// derived widths for the model
	localparam int mem_addr_w = $clog2(mem_words);
	localparam int fifo_ptr_w = $clog2(fifo_depth);
	localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

endpackage

// File: rtl/traffic_generator.sv
`timescale 1ns/10ps

module traffic_generator (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rx_done_tick,
	input  uart_pkg::uart_byte_t rx_data,
	output logic                 tx_start,
	output uart_pkg::uart_byte_t tx_data,
	input  logic                 tx_busy,
	mcb_port_if.master           mem
);

	uart_pkg::gen_state_t state;
	logic                 is_write;
	mem_pkg::word_addr_t  addr;
	// write data while collecting, reply bytes while answering
	mem_pkg::word_t       word;
	// bytes received, then bytes left after the current reply byte
	logic [1:0]           byte_cnt;

	logic                 wr_push;
	logic                 cmd_issue;
	logic                 rd_pop;

	// strobes straight from state and the port levels
	assign wr_push   = (state == uart_pkg::gen_push) && !mem.wr_full;
	assign cmd_issue = (state == uart_pkg::gen_wcmd || state == uart_pkg::gen_rcmd)
		&& !mem.cmd_full;
	assign rd_pop    = (state == uart_pkg::gen_rwait) && !mem.rd_empty;

	assign mem.wr_en         = wr_push;
	assign mem.wr_data       = word;
	assign mem.cmd_en        = cmd_issue;
	assign mem.cmd_instr     = is_write ? mem_pkg::cmd_write : mem_pkg::cmd_read;
	// word address to byte address
	assign mem.cmd_byte_addr = mem_pkg::byte_addr_t'({addr, 2'b00});
	assign mem.rd_en         = rd_pop;

	// one reply byte per idle transmitter
	assign tx_start = (state == uart_pkg::gen_reply) && !tx_busy;
	assign tx_data  = word[7:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= uart_pkg::gen_opcode;
			is_write <= 1'b0;
			byte_cnt <= '0;
		end else begin
			case (state)
				uart_pkg::gen_opcode: begin
					if (rx_done_tick) begin
						byte_cnt <= '0;
						if (rx_data == uart_pkg::op_write || rx_data == uart_pkg::op_read) begin
							is_write <= (rx_data == uart_pkg::op_write);
							state    <= uart_pkg::gen_addr;
						end else begin
							state <= uart_pkg::gen_reply;
						end
					end
				end
				uart_pkg::gen_addr: begin
					if (rx_done_tick)
						state <= is_write ? uart_pkg::gen_wdata : uart_pkg::gen_rcmd;
				end
				uart_pkg::gen_wdata: begin
					if (rx_done_tick) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3)
							state <= uart_pkg::gen_push;
					end
				end
				uart_pkg::gen_push: begin
					if (wr_push)
						state <= uart_pkg::gen_wcmd;
				end
				uart_pkg::gen_wcmd: begin
					// single 'K' once the write is taken
					if (cmd_issue) begin
						byte_cnt <= '0;
						state    <= uart_pkg::gen_reply;
					end
				end
				uart_pkg::gen_rcmd: begin
					if (cmd_issue)
						state <= uart_pkg::gen_rwait;
				end
				uart_pkg::gen_rwait: begin
					if (rd_pop) begin
						byte_cnt <= 2'd3;
						state    <= uart_pkg::gen_reply;
					end
				end
				uart_pkg::gen_reply: begin
					if (tx_start)
						state <= uart_pkg::gen_reply_wait;
				end
				default: begin
					// busy has risen by now
					if (byte_cnt == 2'd0) begin
						state <= uart_pkg::gen_opcode;
					end else begin
						byte_cnt <= byte_cnt - 1'b1;
						state    <= uart_pkg::gen_reply;
					end
				end
			endcase
		end
	end

	// address and word register
	always_ff @(posedge clk) begin
		if (state == uart_pkg::gen_addr && rx_done_tick)
			addr <= rx_data;
		if (state == uart_pkg::gen_opcode && rx_done_tick)
			word <= {24'd0, uart_pkg::reply_bad};
		else if (state == uart_pkg::gen_wdata && rx_done_tick)
			word <= {rx_data, word[31:8]};
		else if (state == uart_pkg::gen_wcmd && cmd_issue)
			word <= {24'd0, uart_pkg::reply_ok};
		else if (rd_pop)
			word <= mem.rd_data;
		else if (tx_start)
			word <= {8'd0, word[31:8]};
	end

endmodule

// File: rtl/uart_core.sv
`timescale 1ns/10ps

module uart_core #(
	parameter int clks_per_bit = uart_pkg::default_clks_per_bit
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                rx,
	output logic                tx,
	output logic                rx_done_tick,
	output uart_pkg::uart_byte_t rx_data,
	input  logic                tx_start,
	input  uart_pkg::uart_byte_t tx_data,
	output logic                tx_busy
);

	localparam int cnt_w = $clog2(clks_per_bit);
	// last cycle of a bit and of half a bit
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clks_per_bit / 2 - 1);

	uart_pkg::rx_state_t  rx_state;
	logic                 rx_meta;
	logic                 rx_sync;
	logic [cnt_w-1:0]     rx_cnt;
	logic [2:0]           rx_bit;
	uart_pkg::uart_byte_t rx_shreg;

	uart_pkg::tx_state_t  tx_state;
	logic [cnt_w-1:0]     tx_cnt;
	logic [2:0]           tx_bit;
	uart_pkg::uart_byte_t tx_shreg;

	// two flops against metastability, line idles high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_state     <= uart_pkg::rx_idle;
			rx_cnt       <= '0;
			rx_bit       <= '0;
			rx_done_tick <= 1'b0;
		end else begin
			rx_done_tick <= 1'b0;
			case (rx_state)
				uart_pkg::rx_idle: begin
					rx_cnt <= '0;
					if (!rx_sync)
						rx_state <= uart_pkg::rx_start;
				end
				uart_pkg::rx_start: begin
					// recheck start bit at its middle, glitches go back to idle
					if (rx_cnt == cnt_half) begin
						rx_cnt   <= '0;
						rx_bit   <= '0;
						rx_state <= rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				uart_pkg::rx_data: begin
					if (rx_cnt == cnt_last) begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= uart_pkg::rx_stop;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				default: begin
					// middle of stop bit, framing error drops the byte
					if (rx_cnt == cnt_last) begin
						rx_done_tick <= rx_sync;
						rx_state     <= uart_pkg::rx_idle;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if (rx_state == uart_pkg::rx_data && rx_cnt == cnt_last)
			rx_shreg <= {rx_sync, rx_shreg[7:1]};
	end

	assign rx_data = rx_shreg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_state <= uart_pkg::tx_idle;
			tx_cnt   <= '0;
			tx_bit   <= '0;
			tx       <= 1'b1;
		end else begin
			case (tx_state)
				uart_pkg::tx_idle: begin
					tx_cnt <= '0;
					if (tx_start) begin
						tx       <= 1'b0;
						tx_state <= uart_pkg::tx_start;
					end
				end
				uart_pkg::tx_start: begin
					if (tx_cnt == cnt_last) begin
						tx_cnt   <= '0;
						tx_bit   <= '0;
						tx       <= tx_shreg[0];
						tx_state <= uart_pkg::tx_data;
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				uart_pkg::tx_data: begin
					if (tx_cnt == cnt_last) begin
						tx_cnt <= '0;
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == 3'd7) begin
							tx       <= 1'b1;
							tx_state <= uart_pkg::tx_stop;
						end else begin
							tx <= tx_shreg[0];
						end
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				default: begin
					if (tx_cnt == cnt_last)
						tx_state <= uart_pkg::tx_idle;
					else
						tx_cnt <= tx_cnt + 1'b1;
				end
			endcase
		end
	end

	// load on start, shift at every bit boundary
	always_ff @(posedge clk) begin
		if (tx_state == uart_pkg::tx_idle && tx_start)
			tx_shreg <= tx_data;
		else if (tx_state != uart_pkg::tx_idle && tx_cnt == cnt_last)
			tx_shreg <= {1'b0, tx_shreg[7:1]};
	end

	assign tx_busy = (tx_state != uart_pkg::tx_idle);

endmodule

// File: rtl/uart_mem_tester.sv
`timescale 1ns/10ps

module uart_mem_tester #(
	parameter int clks_per_bit = uart_pkg::default_clks_per_bit
) (
	input  logic clk,
	input  logic rst_n,
	input  logic uart_rx,
	output logic uart_tx
);

	// uart to generator
	logic                 rx_done_tick;
	uart_pkg::uart_byte_t rx_data;
	logic                 tx_start;
	uart_pkg::uart_byte_t tx_data;
	logic                 tx_busy;

	// user port between generator and memory model
	mcb_port_if mem_if (
		.clk(clk)
	);

	uart_core #(
		.clks_per_bit(clks_per_bit)
	) uart_core_instance1 (
		.clk(clk),
		.rst_n(rst_n),
		.rx(uart_rx),
		.tx(uart_tx),
		.rx_done_tick(rx_done_tick),
		.rx_data(rx_data),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(tx_busy)
	);

	traffic_generator traffic_generator_instance1 (
		.clk(clk),
		.rst_n(rst_n),
		.rx_done_tick(rx_done_tick),
		.rx_data(rx_data),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.mem(mem_if.master)
	);

	// stands in for the lpddr controller
	mcb_port_memory mcb_port_memory_instance1 (
		.clk(clk),
		.rst_n(rst_n),
		.port(mem_if.slave)
	);

endmodule

// File: rtl/uart_pkg.sv
package uart_pkg;

	typedef logic [7:0] uart_byte_t;

	// frame opcodes, ascii 'W' and 'R'
	localparam uart_byte_t op_write = 8'h57;
	localparam uart_byte_t op_read  = 8'h52;

	// replies, ascii 'K' and '?'
	localparam uart_byte_t reply_ok  = 8'h4B;
	localparam uart_byte_t reply_bad = 8'h3F;

	// 115200 baud at 25 MHz
	localparam int default_clks_per_bit = 217;

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;
	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;

	typedef enum logic [3:0] {
		gen_opcode, gen_addr, gen_wdata, gen_push, gen_wcmd,
		gen_rcmd, gen_rwait, gen_reply, gen_reply_wait
	} gen_state_t;

endpackage

// File: uart_mem_tester.f
rtl/mem_pkg.sv
rtl/uart_pkg.sv
rtl/mcb_port_if.sv
rtl/uart_core.sv
rtl/traffic_generator.sv
rtl/mcb_port_memory.sv
rtl/uart_mem_tester.sv
verif/uart_mem_tester_properties.sv
verif/tb_uart_mem_tester.sv

// File: verif/tb_uart_mem_tester.sv
`timescale 1ns/10ps

module tb_uart_mem_tester;

	typedef uart_pkg::uart_byte_t byte_q_t [$];

	localparam int bit_cycles = 16;
	// frame bytes per behaviour: 8, 160, 3, 16, 6
	localparam int frame_bytes = 8 + 160 + 3 + 16 + 6;
	// reply bytes per behaviour: 5, 100, 5, 10, 4
	localparam int reply_bytes = 5 + 100 + 5 + 10 + 4;
	localparam int cycle_limit = (frame_bytes + reply_bytes) * 10 * bit_cycles * 2;

	logic clk;
	logic rst_n;
	logic uart_rx;
	logic uart_tx;

	// expected memory contents, survive reset like the dut
	mem_pkg::word_t       model [mem_pkg::mem_words];
	uart_pkg::uart_byte_t reply_q [$];
	uart_pkg::uart_byte_t exp_q [$];

	int mismatch_cnt   = 0;
	int missing_cnt    = 0;
	int unexpected_cnt = 0;
	int seed           = 32'h133a_b26f;
	int cycles         = 0;

	uart_mem_tester #(
		.clks_per_bit(bit_cycles)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// expected reply for one complete frame, applies writes to the model
	function automatic byte_q_t expected_reply(input byte_q_t frame,
		inout mem_pkg::word_t mem_model [mem_pkg::mem_words]);
		byte_q_t        reply;
		mem_pkg::word_t w;
		case (frame[0])
			uart_pkg::op_write: begin
				w = {frame[5], frame[4], frame[3], frame[2]};
				mem_model[frame[1]] = w;
				reply.push_back(uart_pkg::reply_ok);
			end
			uart_pkg::op_read: begin
				w = mem_model[frame[1]];
				// lsb first
				for (int i = 0; i < 4; i++)
					reply.push_back(w[8*i +: 8]);
			end
			default: reply.push_back(uart_pkg::reply_bad);
		endcase
		return reply;
	endfunction

	function automatic byte_q_t write_frame(input mem_pkg::word_addr_t a,
		input mem_pkg::word_t w);
		byte_q_t f;
		f.push_back(uart_pkg::op_write);
		f.push_back(a);
		for (int i = 0; i < 4; i++)
			f.push_back(w[8*i +: 8]);
		return f;
	endfunction

	function automatic byte_q_t read_frame(input mem_pkg::word_addr_t a);
		byte_q_t f;
		f.push_back(uart_pkg::op_read);
		f.push_back(a);
		return f;
	endfunction

	// one bit on the line for a full bit period
	task automatic drive_bit(input logic v);
		@(posedge clk);
		uart_rx <= v;
		repeat (bit_cycles - 1) @(posedge clk);
	endtask

	// 8n1, lsb first
	task automatic send_byte(input uart_pkg::uart_byte_t b);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(1'b1);
	endtask

	task automatic send_frame(input byte_q_t frame);
		foreach (frame[i])
			send_byte(frame[i]);
	endtask

	// wait until the compare process has used up every expected byte
	task automatic wait_replies(input int n);
		int waited;
		waited = 0;
		while (exp_q.size() > 0 && waited < n * 10 * bit_cycles * 2 + 64) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() > 0) begin
			$display("missing reply: %0d of %0d expected bytes never came out on uart_tx",
				exp_q.size(), n);
			missing_cnt += exp_q.size();
			exp_q.delete();
		end
	endtask

	task automatic run_frame(input byte_q_t frame);
		byte_q_t expect_bytes;
		expect_bytes = expected_reply(frame, model);
		foreach (expect_bytes[i])
			exp_q.push_back(expect_bytes[i]);
		send_frame(frame);
		wait_replies(expect_bytes.size());
	endtask

	// decode uart_tx, sample each bit in its middle
	initial begin : reply_monitor
		uart_pkg::uart_byte_t b;
		forever begin
			@(posedge clk);
			if (rst_n && uart_tx === 1'b0) begin
				repeat (bit_cycles / 2) @(posedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (bit_cycles) @(posedge clk);
					b[i] = uart_tx;
				end
				repeat (bit_cycles) @(posedge clk);
				if (uart_tx !== 1'b1) begin
					$display("framing error: stop bit on uart_tx was not high");
					unexpected_cnt++;
				end else begin
					reply_q.push_back(b);
				end
			end
		end
	end

	// match each received byte against the expected queue
	initial begin : reply_compare
		uart_pkg::uart_byte_t got;
		uart_pkg::uart_byte_t want;
		forever begin
			@(posedge clk);
			while (reply_q.size() > 0) begin
				got = reply_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("unexpected reply byte 0x%02h on uart_tx with none pending", got);
					unexpected_cnt++;
				end else begin
					want = exp_q.pop_front();
					if (got !== want) begin
						$display("** Error: uart_tx reply got 0x%02h expected 0x%02h", got, want);
						mismatch_cnt++;
					end
				end
			end
		end
	end

	initial begin : watchdog
		while (cycles < cycle_limit)
			@(posedge clk) cycles++;
		$display("timeout: run still going after %0d cycles", cycles);
		$display("errors: mismatch %0d, missing %0d, unexpected %0d, assertion %0d",
			mismatch_cnt, missing_cnt, unexpected_cnt, u_dut.u_props.fail_cnt);
		$display("Checks failed");
		$finish;
	end

	initial begin : stimulus
		byte_q_t             frame;
		mem_pkg::word_addr_t addrs [$];
		mem_pkg::word_addr_t a;
		mem_pkg::word_addr_t tmp;
		mem_pkg::word_t      w;
		int                  j;
		bit                  seen;
		int                  quiet_bad;
		int                  total;

		rst_n   = 1'b0;
		uart_rx = 1'b1;
		quiet_bad = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);

		// write then read back one word
		run_frame(write_frame(8'h05, 32'hC0DE_5A3E));
		run_frame(read_frame(8'h05));

		// 20 writes into 16 slots, so some addresses repeat
		for (int i = 0; i < 20; i++) begin
			a = 8'h20 + 8'($unsigned($random(seed)) % 16);
			w = $random(seed);
			run_frame(write_frame(a, w));
			seen = 1'b0;
			foreach (addrs[k])
				if (addrs[k] == a)
					seen = 1'b1;
			if (!seen)
				addrs.push_back(a);
		end
		// shuffle read order
		for (int i = addrs.size() - 1; i > 0; i--) begin
			j = int'($unsigned($random(seed)) % (i + 1));
			tmp = addrs[i];
			addrs[i] = addrs[j];
			addrs[j] = tmp;
		end
		foreach (addrs[k])
			run_frame(read_frame(addrs[k]));

		// unknown opcode, then a normal read
		frame.push_back(8'h41);
		run_frame(frame);
		run_frame(read_frame(8'h05));

		// top and bottom word, no aliasing
		w = $random(seed);
		run_frame(write_frame(8'hFF, w));
		w = $random(seed);
		run_frame(write_frame(8'h00, w));
		run_frame(read_frame(8'hFF));
		run_frame(read_frame(8'h00));

		// reset in the middle of a write frame, model left untouched
		frame = write_frame(8'h05, 32'h5555_AAAA);
		for (int i = 0; i < 4; i++)
			send_byte(frame[i]);
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// two byte times of quiet line
		for (int i = 0; i < 2 * 10 * bit_cycles; i++) begin
			@(posedge clk);
			if (uart_tx !== 1'b1)
				quiet_bad++;
		end
		if (quiet_bad > 0) begin
			$display("uart_tx left idle for %0d cycles after reset with no frame sent", quiet_bad);
			unexpected_cnt++;
		end
		run_frame(read_frame(8'h05));

		// room for a stray byte after the last reply to show up
		repeat (3 * 10 * bit_cycles) @(posedge clk);
		total = mismatch_cnt + missing_cnt + unexpected_cnt + u_dut.u_props.fail_cnt;
		$display("errors: mismatch %0d, missing %0d, unexpected %0d, assertion %0d",
			mismatch_cnt, missing_cnt, unexpected_cnt, u_dut.u_props.fail_cnt);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: verif/uart_mem_tester_properties.sv
`timescale 1ns/10ps

module uart_mem_tester_properties (
	input logic clk,
	input logic rst_n,
	input logic cmd_en,
	input logic cmd_full,
	input logic wr_en,
	input logic wr_full,
	input logic rd_en,
	input logic rd_empty,
	input logic uart_tx
);

	// one counter per property, summed for the testbench
	int cmd_fails = 0;
	int wr_fails  = 0;
	int rd_fails  = 0;
	int idle_fails = 0;
	int fail_cnt;

	assign fail_cnt = cmd_fails + wr_fails + rd_fails + idle_fails;

	// no command strobe into a busy command path
	cmd_not_full: assert property (@(posedge clk) disable iff (!rst_n) !(cmd_en && cmd_full))
		else begin
			$error("cmd_en high while cmd_full is set");
			cmd_fails++;
		end

	// write fifo never pushed when full
	wr_not_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && wr_full))
		else begin
			$error("wr_en high while wr_full is set");
			wr_fails++;
		end

	// read fifo never popped when empty
	rd_not_empty: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && rd_empty))
		else begin
			$error("rd_en high while rd_empty is set");
			rd_fails++;
		end

	// serial line idles high right after reset
	tx_idle_after_reset: assert property (@(posedge clk) !rst_n |=> uart_tx)
		else begin
			$error("uart_tx not high in the cycle after reset");
			idle_fails++;
		end

endmodule

// top level sees both the port bundle and the serial line
bind uart_mem_tester uart_mem_tester_properties u_props (
	.clk(clk),
	.rst_n(rst_n),
	.cmd_en(mem_if.cmd_en),
	.cmd_full(mem_if.cmd_full),
	.wr_en(mem_if.wr_en),
	.wr_full(mem_if.wr_full),
	.rd_en(mem_if.rd_en),
	.rd_empty(mem_if.rd_empty),
	.uart_tx(uart_tx)
);
